// ==== Makefile ====
VERILATOR  = verilator
TOP        = tb_conv_channel_accum
FILELIST   = conv_channel_accum.f
OBJ_DIR    = obj_dir
LOG        = sim.log
LINT_FLAGS = --lint-only --timing --top-module $(TOP)
SIM_FLAGS  = --binary --timing --assert --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q ">>> PASS" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== conv_channel_accum.f ====
source/conv_accum_pkg.sv
source/fp32_adder.sv
source/plane_fifo.sv
source/channel_accumulator.sv
source/accum_apb_regs.sv
source/conv_channel_accum_top.sv
sim/tb_conv_channel_accum.sv

// ==== sim/tb_conv_channel_accum.sv ====
`timescale 1ns/1ps

module tb_conv_channel_accum import conv_accum_pkg::*; ();

  localparam int NUM_ROWS      = 4;
  localparam int APB_TIMEOUT   = 16;
  localparam int DRAIN_TIMEOUT = 200;

  //////////////////////////////////////////////////
  // Stimulus table with expected register counts
  localparam int ROW_CHANNELS [NUM_ROWS] = '{1, 2, 3, 7};
  localparam int ROW_GAPS     [NUM_ROWS] = '{0, 1, 0, 1};
  localparam int ROW_IMAGES   [NUM_ROWS] = '{2, 1, 2, 2};
  localparam int ROW_PLANES   [NUM_ROWS] = '{2, 2, 6, 14};
  localparam int ROW_OUTS     [NUM_ROWS] = '{128, 64, 128, 128};

  logic              clk;
  logic              reset;
  logic [3:0]        paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [31:0]       pwdata;
  logic [31:0]       prdata;
  logic              pready;
  logic              pslverr;
  logic              pix_valid;
  logic [DATA_W-1:0] pix_data;
  logic              sum_valid;
  logic [DATA_W-1:0] sum_data;

  int          cycle = 0;
  int          check_errors = 0;
  int          timeout_errors = 0;
  logic [31:0] rng_state;
  logic [31:0] exp_data_q [$];
  int          exp_cycle_q [$];
  logic [31:0] mon_data;
  int          mon_cycle;

  conv_channel_accum_top DUT (
    .clk(clk), .reset(reset), .paddr(paddr), .psel(psel), .penable(penable),
    .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .pix_valid(pix_valid), .pix_data(pix_data),
    .sum_valid(sum_valid), .sum_data(sum_data)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Exact fp32 form of an integer below 2**24
  function automatic logic [31:0] int_to_fp32(input logic [31:0] n);
    int          msb;
    logic [31:0] frac;
    msb = 0;
    for (int i = 0; i < 24; i++) begin
      if (n[i]) begin
        msb = i;
      end
    end
    frac = n << (23 - msb);
    return (n == 32'd0) ? 32'd0 : {1'b0, 8'(127 + msb), frac[22:0]};
  endfunction

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      check_errors++;
      $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic end_run();
    $display("Errors: %0d check, %0d timeout", check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  // One APB transfer with pslverr and read data checks
  task automatic apb_check(input string what, input logic [3:0] addr, input logic write,
                           input logic [31:0] data, input logic exp_err);
    int n;
    @(posedge clk);
    #1;
    paddr   = addr;
    pwrite  = write;
    pwdata  = data;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    n = 0;
    while (!pready && n < APB_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!pready) begin
      timeout_errors++;
      $display("Timeout while waiting for pready on %s", what);
      end_run();
    end else begin
      check_word({"pslverr on ", what}, {31'd0, pslverr}, {31'd0, exp_err});
      if (!write && !exp_err) begin
        check_word(what, prdata, data);
      end
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
    end
  endtask

  task automatic stream_images(input int channels, input int gaps, input int images);
    int unsigned sums [IMAGE_SIZE];
    logic [31:0] val;
    int          gap;
    for (int img = 0; img < images; img++) begin
      for (int ch = 0; ch < channels; ch++) begin
        for (int p = 0; p < IMAGE_SIZE; p++) begin
          rng_state = xorshift32(rng_state);
          val = {24'd0, rng_state[7:0]};
          // A new image restarts every position at the first channel
          sums[p] = (ch == 0) ? val : sums[p] + val;
          gap = 0;
          if (gaps != 0) begin
            rng_state = xorshift32(rng_state);
            gap = {30'd0, rng_state[1:0]};
          end
          repeat (gap) begin
            @(posedge clk);
            #1;
            pix_valid = 1'b0;
          end
          @(posedge clk);
          #1;
          pix_valid = 1'b1;
          pix_data  = int_to_fp32(val);
          if (ch == channels - 1) begin
            exp_data_q.push_back(int_to_fp32(sums[p]));
            exp_cycle_q.push_back(cycle);
          end
        end
      end
    end
    @(posedge clk);
    #1;
    pix_valid = 1'b0;
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (exp_data_q.size() != 0 && n < DRAIN_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (exp_data_q.size() != 0) begin
      timeout_errors++;
      $display("Timeout with %0d output sums still missing", exp_data_q.size());
      end_run();
    end
  endtask

  //////////////////////////////////////////////////
  // Output checker for order, data and latency
  always @(negedge clk) begin
    if (!reset && sum_valid) begin
      assert (exp_data_q.size() != 0) else begin
        check_errors++;
        $display("FAIL %0t: sum_valid while no sum is expected", $time);
      end
      if (exp_data_q.size() != 0) begin
        mon_data  = exp_data_q.pop_front();
        mon_cycle = exp_cycle_q.pop_front();
        check_word("sum_data", sum_data, mon_data);
        check_word("output latency", 32'(cycle - mon_cycle), 32'd3);
      end
    end
  end

  initial begin
    reset     = 1'b1;
    paddr     = 4'h0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = 32'd0;
    pix_valid = 1'b0;
    pix_data  = '0;
    rng_state = 32'h949b;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;

    @(negedge clk);
    check_word("sum_valid after reset", {31'd0, sum_valid}, 32'd0);
    apb_check("REG_CHANNELS after reset", REG_CHANNELS, 1'b0, 32'd1, 1'b0);
    apb_check("REG_PLANES after reset", REG_PLANES, 1'b0, 32'd0, 1'b0);
    apb_check("REG_OUTS after reset", REG_OUTS, 1'b0, 32'd0, 1'b0);

    // Unmapped address and out of range channel counts
    apb_check("unmapped read", 4'h2, 1'b0, 32'd0, 1'b1);
    apb_check("REG_CHANNELS write 5", REG_CHANNELS, 1'b1, 32'd5, 1'b0);
    apb_check("REG_CHANNELS write 0", REG_CHANNELS, 1'b1, 32'd0, 1'b1);
    apb_check("REG_CHANNELS write max+1", REG_CHANNELS, 1'b1, 32'(MAX_CHANNELS + 1), 1'b1);
    apb_check("REG_CHANNELS after rejects", REG_CHANNELS, 1'b0, 32'd5, 1'b0);

    for (int r = 0; r < NUM_ROWS; r++) begin
      apb_check("REG_CHANNELS write", REG_CHANNELS, 1'b1, 32'(ROW_CHANNELS[r]), 1'b0);
      apb_check("REG_CTRL start", REG_CTRL, 1'b1, 32'd1, 1'b0);
      apb_check("REG_CTRL read", REG_CTRL, 1'b0, 32'd0, 1'b0);
      apb_check("REG_PLANES after start", REG_PLANES, 1'b0, 32'd0, 1'b0);
      apb_check("REG_OUTS after start", REG_OUTS, 1'b0, 32'd0, 1'b0);
      stream_images(ROW_CHANNELS[r], ROW_GAPS[r], ROW_IMAGES[r]);
      wait_drained();
      apb_check("REG_PLANES", REG_PLANES, 1'b0, 32'(ROW_PLANES[r]), 1'b0);
      apb_check("REG_OUTS", REG_OUTS, 1'b0, 32'(ROW_OUTS[r]), 1'b0);
    end
    end_run();
  end

endmodule

// ==== source/accum_apb_regs.sv ====
`timescale 1ns/1ps

module accum_apb_regs import conv_accum_pkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic [3:0]          paddr,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  logic [31:0]         pwdata,
  output logic [31:0]         prdata,
  output logic                pready,
  output logic                pslverr,
  input  logic                plane_done,
  input  logic                sum_valid,
  output logic [CH_CNT_W-1:0] num_channels,
  output logic                start
);

  logic        access;
  logic        addr_ok;
  logic        ch_bad;
  logic        wr_ok;
  logic [31:0] plane_cnt;
  logic [31:0] out_cnt;

  //////////////////////////////////////////////////
  // Transfer decode and checks
  assign access  = psel && penable;
  assign addr_ok = paddr == REG_CTRL || paddr == REG_CHANNELS ||
                   paddr == REG_PLANES || paddr == REG_OUTS;
  assign ch_bad  = pwrite && paddr == REG_CHANNELS &&
                   (pwdata == 32'd0 || pwdata > 32'(MAX_CHANNELS));
  assign wr_ok   = access && pwrite && addr_ok && !ch_bad;

  assign pready  = 1'b1;
  assign pslverr = access && (!addr_ok || ch_bad);

  always_comb begin
    prdata = 32'd0;
    if (access && !pwrite) begin
      case (paddr)
        REG_CHANNELS: prdata = {{(32 - CH_CNT_W){1'b0}}, num_channels};
        REG_PLANES:   prdata = plane_cnt;
        REG_OUTS:     prdata = out_cnt;
        default:      prdata = 32'd0;
      endcase
    end
  end

  // Channel count and start pulse
  always_ff @(posedge clk) begin
    if (reset) begin
      num_channels <= CH_CNT_W'(1);
      start        <= 1'b0;
    end else begin
      start <= wr_ok && paddr == REG_CTRL && pwdata[0];
      if (wr_ok && paddr == REG_CHANNELS) begin
        num_channels <= pwdata[CH_CNT_W-1:0];
      end
    end
  end

  //////////////////////////////////////////////////
  // Progress counters
  always_ff @(posedge clk) begin
    if (reset || start) begin
      plane_cnt <= 32'd0;
      out_cnt   <= 32'd0;
    end else begin
      plane_cnt <= plane_cnt + {31'd0, plane_done};
      out_cnt   <= out_cnt + {31'd0, sum_valid};
    end
  end

  a_start_pulse: assert property (@(posedge clk) disable iff (reset)
    start |=> !start);

  a_penable_psel: assert property (@(posedge clk) disable iff (reset)
    penable |-> psel);

endmodule

// ==== source/channel_accumulator.sv ====
`timescale 1ns/1ps

module channel_accumulator import conv_accum_pkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  input  logic [CH_CNT_W-1:0] num_channels,
  input  logic                pix_valid,
  input  logic [DATA_W-1:0]   pix_data,
  output logic                plane_done,
  output logic                sum_valid,
  output logic [DATA_W-1:0]   sum_data
);

  logic [PIX_CNT_W-1:0] pix_cnt;
  logic [CH_CNT_W-1:0]  ch_cnt;
  logic                 first_ch;
  logic                 last_ch;
  logic                 plane_end;

  logic                 pix_q_valid;
  logic [DATA_W-1:0]    pix_q;
  logic                 first_q;
  logic                 last_q;

  logic                 fifo_wr;
  logic                 fifo_rd;
  logic [DATA_W-1:0]    fifo_data;
  logic                 fifo_full;
  logic                 fifo_empty;

  logic [DATA_W-1:0]    partial;
  logic                 add_valid;
  logic                 add_last;
  logic [DATA_W-1:0]    add_sum;

  //////////////////////////////////////////////////
  // Pixel and channel position
  assign first_ch   = ch_cnt == '0;
  assign last_ch    = ch_cnt == num_channels - 1'b1;
  assign plane_end  = pix_cnt == PIX_CNT_W'(IMAGE_SIZE - 1);
  assign plane_done = pix_valid && plane_end;

  always_ff @(posedge clk) begin
    if (reset || start) begin
      pix_cnt <= '0;
      ch_cnt  <= '0;
    end else if (pix_valid) begin
      if (plane_end) begin
        pix_cnt <= '0;
        // Wrap to channel 0 for the next image
        ch_cnt  <= last_ch ? '0 : ch_cnt + 1'b1;
      end else begin
        pix_cnt <= pix_cnt + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Input register lined up with the FIFO read data
  always_ff @(posedge clk) begin
    if (reset) begin
      pix_q_valid <= 1'b0;
      first_q     <= 1'b0;
      last_q      <= 1'b0;
    end else begin
      pix_q_valid <= pix_valid;
      first_q     <= first_ch;
      last_q      <= last_ch;
    end
  end

  always_ff @(posedge clk) begin
    pix_q <= pix_data;
  end

  // No previous sum on the first channel
  assign fifo_rd = pix_valid && !first_ch;
  assign partial = first_q ? '0 : fifo_data;

  fp32_adder u_adder (
    .clk      (clk),
    .reset    (reset),
    .in_valid (pix_q_valid),
    .a        (pix_q),
    .b        (partial),
    .in_last  (last_q),
    .out_valid(add_valid),
    .out_last (add_last),
    .sum      (add_sum)
  );

  // Last channel goes out and earlier channels go back to the buffer
  assign fifo_wr   = add_valid && !add_last;
  assign sum_valid = add_valid && add_last;
  assign sum_data  = add_sum;

  plane_fifo u_fifo (
    .clk    (clk),
    .reset  (reset),
    .clear  (start),
    .wr_en  (fifo_wr),
    .wr_data(add_sum),
    .rd_en  (fifo_rd),
    .rd_data(fifo_data),
    .full   (fifo_full),
    .empty  (fifo_empty)
  );

  a_no_write_full: assert property (@(posedge clk) disable iff (reset)
    !(fifo_wr && fifo_full));

  a_no_read_empty: assert property (@(posedge clk) disable iff (reset)
    !(fifo_rd && fifo_empty));

endmodule

// ==== source/conv_accum_pkg.sv ====
package conv_accum_pkg;

  //////////////////////////////////////////////////
  // Plane geometry
  localparam int IMAGE_W    = 8;
  localparam int IMAGE_SIZE = IMAGE_W * IMAGE_W;
  localparam int PIX_CNT_W  = $clog2(IMAGE_SIZE + 1);

  //////////////////////////////////////////////////
  // Channel limits
  localparam int MAX_CHANNELS = 512;
  localparam int CH_CNT_W     = $clog2(MAX_CHANNELS + 1);

  // fp32 datapath
  localparam int DATA_W      = 32;
  localparam int ADD_LATENCY = 2;

  // One plane of partial sums
  localparam int FIFO_DEPTH = IMAGE_SIZE;

  //////////////////////////////////////////////////
  // APB register map, byte addresses
  localparam logic [3:0] REG_CTRL     = 4'h0;
  localparam logic [3:0] REG_CHANNELS = 4'h4;
  localparam logic [3:0] REG_PLANES   = 4'h8;
  localparam logic [3:0] REG_OUTS     = 4'hC;

endpackage

// ==== source/conv_channel_accum_top.sv ====
`timescale 1ns/1ps

module conv_channel_accum_top import conv_accum_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic [3:0]        paddr,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [31:0]       pwdata,
  output logic [31:0]       prdata,
  output logic              pready,
  output logic              pslverr,
  input  logic              pix_valid,
  input  logic [DATA_W-1:0] pix_data,
  output logic              sum_valid,
  output logic [DATA_W-1:0] sum_data
);

  logic [CH_CNT_W-1:0] num_channels;
  logic                start;
  logic                plane_done;

  // Register block, also counts stream progress
  accum_apb_regs u_regs (
    .clk         (clk),
    .reset       (reset),
    .paddr       (paddr),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .plane_done  (plane_done),
    .sum_valid   (sum_valid),
    .num_channels(num_channels),
    .start       (start)
  );

  channel_accumulator u_accum (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .num_channels(num_channels),
    .pix_valid   (pix_valid),
    .pix_data    (pix_data),
    .plane_done  (plane_done),
    .sum_valid   (sum_valid),
    .sum_data    (sum_data)
  );

endmodule

// ==== source/fp32_adder.sv ====
`timescale 1ns/1ps

module fp32_adder import conv_accum_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              in_valid,
  input  logic [DATA_W-1:0] a,
  input  logic [DATA_W-1:0] b,
  input  logic              in_last,
  output logic              out_valid,
  output logic              out_last,
  output logic [DATA_W-1:0] sum
);

  // Leading zeros of a 24-bit mantissa, 24 when it is all zero
  function automatic logic [4:0] lead_zeros(input logic [23:0] m);
    logic [4:0] n;
    n = 5'd24;
    for (int i = 0; i < 24; i++) begin
      if (m[i]) begin
        n = 5'(23 - i);
      end
    end
    return n;
  endfunction

  //////////////////////////////////////////////////
  // Stage 1: order, align, add
  logic              swap;
  logic [DATA_W-1:0] op_big;
  logic [DATA_W-1:0] op_small;
  logic [23:0]       man_big;
  logic [23:0]       man_small;
  logic [23:0]       man_aligned;
  logic [7:0]        exp_diff;
  logic              eff_sub;
  logic [24:0]       man_sum;

  logic              s1_valid;
  logic              s1_last;
  logic              s1_sign;
  logic [7:0]        s1_exp;
  logic [24:0]       s1_man;

  // Compare magnitudes on exponent and fraction together
  assign swap     = b[30:0] > a[30:0];
  assign op_big   = swap ? b : a;
  assign op_small = swap ? a : b;

  // Hidden bit, exponent zero counts as zero
  assign man_big   = (op_big[30:23] != 8'd0) ? {1'b1, op_big[22:0]} : 24'd0;
  assign man_small = (op_small[30:23] != 8'd0) ? {1'b1, op_small[22:0]} : 24'd0;

  assign exp_diff    = op_big[30:23] - op_small[30:23];
  assign man_aligned = man_small >> exp_diff;
  assign eff_sub     = op_big[31] ^ op_small[31];
  assign man_sum     = eff_sub ? ({1'b0, man_big} - {1'b0, man_aligned})
                               : ({1'b0, man_big} + {1'b0, man_aligned});

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s1_last  <= 1'b0;
    end else begin
      s1_valid <= in_valid;
      s1_last  <= in_last;
    end
  end

  always_ff @(posedge clk) begin
    s1_sign <= op_big[31];
    s1_exp  <= op_big[30:23];
    s1_man  <= man_sum;
  end

  //////////////////////////////////////////////////
  // Stage 2: normalise and pack
  logic [4:0]        lz;
  logic [8:0]        norm_exp;
  logic [23:0]       norm_man;
  logic              res_zero;
  logic [DATA_W-1:0] res_word;

  assign lz = lead_zeros(s1_man[23:0]);

  always_comb begin
    norm_man = s1_man[23:0];
    norm_exp = {1'b0, s1_exp};
    res_zero = 1'b0;
    if (s1_man[24]) begin
      // Carry out of the add, one step right
      norm_man = s1_man[24:1];
      norm_exp = {1'b0, s1_exp} + 9'd1;
    end else if (s1_man[23:0] == 24'd0 || {4'd0, lz} >= {1'b0, s1_exp}) begin
      // Cancelled or would go denormal
      res_zero = 1'b1;
    end else begin
      norm_man = s1_man[23:0] << lz;
      norm_exp = {1'b0, s1_exp} - {4'd0, lz};
    end
  end

  // Zero is always packed as +0
  assign res_word = res_zero ? '0 : {s1_sign, norm_exp[7:0], norm_man[22:0]};

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else begin
      out_valid <= s1_valid;
      out_last  <= s1_last;
    end
  end

  always_ff @(posedge clk) begin
    sum <= res_word;
  end

endmodule

// ==== source/plane_fifo.sv ====
`timescale 1ns/1ps

module plane_fifo import conv_accum_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              clear,
  input  logic              wr_en,
  input  logic [DATA_W-1:0] wr_data,
  input  logic              rd_en,
  output logic [DATA_W-1:0] rd_data,
  output logic              full,
  output logic              empty
);

  logic [DATA_W-1:0]                mem [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0]    wr_ptr;
  logic [$clog2(FIFO_DEPTH)-1:0]    rd_ptr;
  logic [$clog2(FIFO_DEPTH+1)-1:0]  count;

  // Depth is a power of two, pointers wrap on their own
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage and registered read port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
    if (rd_en) begin
      rd_data <= mem[rd_ptr];
    end
  end

  assign full  = 32'(count) == FIFO_DEPTH;
  assign empty = count == '0;

endmodule
